// File: compile.f
logic/aurora_mgmt_pkg.sv
logic/aurora_reg_ctrl.sv
logic/status_sync.sv
logic/bist_lock_timer.sv
logic/aurora_err_counters.sv
logic/aurora_readback.sv
logic/aurora_mgmt_core.sv
sim/aurora_mgmt_assertions.sv
sim/tb_aurora_mgmt_core.sv

// File: logic/aurora_err_counters.sv
`timescale 1ns/1ns

module aurora_err_counters (
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  input  logic                       mac_clear_i,          // Held clear from control reg
  input  logic                       overrun_pulse_i,
  input  logic                       checksum_err_pulse_i,
  input  logic                       crit_err_i,           // Synchronized PHY flag
  output aurora_mgmt_pkg::reg_data_t overruns_o,
  output aurora_mgmt_pkg::reg_data_t checksum_errors_o,
  output logic                       crit_latch_o
);

  logic clear;

  assign clear = bus_rst || mac_clear_i;

  //--------------------------------------------------
  // Event counters
  //--------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (clear) begin
      overruns_o <= '0;
    end else if (overrun_pulse_i) begin
      overruns_o <= overruns_o + 1'b1; // Wraps at 32 bits
    end
  end

  always_ff @(posedge bus_clk) begin
    if (clear) begin
      checksum_errors_o <= '0;
    end else if (checksum_err_pulse_i) begin
      checksum_errors_o <= checksum_errors_o + 1'b1;
    end
  end

  //--------------------------------------------------
  // Sticky critical error
  //--------------------------------------------------
  // Stays set after the flag drops, until software
  // pulses mac_clear
  always_ff @(posedge bus_clk) begin
    if (clear) begin
      crit_latch_o <= 1'b0;
    end else if (crit_err_i) begin
      crit_latch_o <= 1'b1;
    end
  end

endmodule

// File: logic/aurora_mgmt_core.sv
`timescale 1ns/1ns

module aurora_mgmt_core (
  input  logic                          bus_clk,
  input  logic                          bus_rst,
  // Register port
  input  aurora_mgmt_pkg::reg_wr_t      reg_wr_i,
  input  logic                          reg_rd_req_i,
  input  aurora_mgmt_pkg::reg_addr_t    reg_rd_addr_i,
  output logic                          reg_rd_resp_o,
  output aurora_mgmt_pkg::reg_data_t    reg_rd_data_o,
  // PHY flags, asynchronous
  input  aurora_mgmt_pkg::phy_flags_t   phy_flags_i,
  // MAC events and BIST, on bus_clk
  input  logic                          overrun_pulse_i,
  input  logic                          checksum_err_pulse_i,
  input  logic                          bist_locked_i,
  input  aurora_mgmt_pkg::bist_count_t  bist_samps_i,
  input  aurora_mgmt_pkg::bist_count_t  bist_errors_i,
  // Control fields to the PHY and MAC
  output aurora_mgmt_pkg::aurora_ctrl_t ctrl_o
);

  logic                        rd_hit;
  aurora_mgmt_pkg::reg_addr_t  rd_sel;
  aurora_mgmt_pkg::phy_flags_t flags_bclk;
  aurora_mgmt_pkg::lock_time_t lock_time;
  aurora_mgmt_pkg::reg_data_t  overruns;
  aurora_mgmt_pkg::reg_data_t  checksum_errors;
  logic                        crit_latch;

  //--------------------------------------------------
  // Register decode and control word
  //--------------------------------------------------
  aurora_reg_ctrl i_aurora_reg_ctrl (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_req_i (reg_rd_req_i),
    .reg_rd_addr_i(reg_rd_addr_i),
    .ctrl_o       (ctrl_o),       // Also read by the blocks below
    .rd_hit_o     (rd_hit),
    .rd_sel_o     (rd_sel)
  );

  // PHY flags into the bus domain
  status_sync i_status_sync (
    .bus_clk(bus_clk),
    .flags_i(phy_flags_i),
    .flags_o(flags_bclk)
  );

  //--------------------------------------------------
  // Datapath
  //--------------------------------------------------
  bist_lock_timer i_bist_lock_timer (
    .bus_clk     (bus_clk),
    .checker_en_i(ctrl_o.checker_en),
    .locked_i    (bist_locked_i),
    .lock_time_o (lock_time)
  );

  aurora_err_counters i_aurora_err_counters (
    .bus_clk             (bus_clk),
    .bus_rst             (bus_rst),
    .mac_clear_i         (ctrl_o.mac_clear),
    .overrun_pulse_i     (overrun_pulse_i),
    .checksum_err_pulse_i(checksum_err_pulse_i),
    .crit_err_i          (flags_bclk.crit_err),
    .overruns_o          (overruns),
    .checksum_errors_o   (checksum_errors),
    .crit_latch_o        (crit_latch)
  );

  aurora_readback i_aurora_readback (
    .bus_clk          (bus_clk),
    .bus_rst          (bus_rst),
    .rd_hit_i         (rd_hit),
    .rd_sel_i         (rd_sel),
    .flags_i          (flags_bclk),
    .lock_time_i      (lock_time),
    .bist_locked_i    (bist_locked_i),
    .crit_latch_i     (crit_latch),
    .overruns_i       (overruns),
    .checksum_errors_i(checksum_errors),
    .bist_samps_i     (bist_samps_i),
    .bist_errors_i    (bist_errors_i),
    .rd_resp_o        (reg_rd_resp_o),
    .rd_data_o        (reg_rd_data_o)
  );

endmodule

// File: logic/aurora_mgmt_pkg.sv
package aurora_mgmt_pkg;

  //--------------------------------------------------
  // Widths and basic types
  //--------------------------------------------------
  localparam int LOCK_TIMER_WIDTH = 20;
  localparam int SYNC_STAGES      = 2;

  typedef logic [13:0]                 reg_addr_t;
  typedef logic [31:0]                 reg_data_t;
  typedef logic [47:0]                 bist_count_t;
  typedef logic [5:0]                  gen_rate_t;
  typedef logic [LOCK_TIMER_WIDTH-1:0] lock_time_t;

  //--------------------------------------------------
  // Register map
  //--------------------------------------------------
  localparam reg_addr_t REG_BASE = 14'h0000;

  localparam reg_addr_t REG_MAC_CTRL_STATUS = REG_BASE + 14'h2030; // W: control, R: core status
  localparam reg_addr_t REG_PHY_STATUS      = REG_BASE + 14'h2034;
  localparam reg_addr_t REG_OVERRUNS        = REG_BASE + 14'h2038;
  localparam reg_addr_t REG_CHECKSUM_ERRORS = REG_BASE + 14'h203C;
  localparam reg_addr_t REG_BIST_SAMPS      = REG_BASE + 14'h2040; // Upper 32 of 48-bit count
  localparam reg_addr_t REG_BIST_ERRORS     = REG_BASE + 14'h2044; // Lower 32 of 48-bit count
  localparam reg_addr_t REG_ID              = REG_BASE + 14'h2048;

  // Reads back as "aurora" in a loose hex spelling
  localparam reg_data_t ID_WORD = 32'h4012_0124;

  // Only the BIST checker is enabled out of reset
  localparam reg_data_t CTRL_RESET_VALUE = 32'h0000_0001;

  //--------------------------------------------------
  // Aurora control word, bit 0 is checker_en
  //--------------------------------------------------
  typedef struct packed {
    logic [20:0] reserved;    // [31:11] kept as written
    logic        mac_clear;   // [10]
    logic        phy_areset;  // [9]
    gen_rate_t   gen_rate;    // [8:3]
    logic        loopback_en; // [2]
    logic        gen_en;      // [1]
    logic        checker_en;  // [0]
  } aurora_ctrl_t;

  // Status flags from the PHY clock domain
  typedef struct packed {
    logic channel_up;
    logic hard_err;
    logic soft_err;
    logic crit_err;
    logic gt_pll_lock;
    logic mmcm_locked;
    logic qpll_reset;
    logic qpll_lock;
    logic qpll_refclk_lost;
  } phy_flags_t;

  // Register write request, 47 bits
  typedef struct packed {
    logic      req;
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

endpackage

// File: logic/aurora_readback.sv
`timescale 1ns/1ns

module aurora_readback (
  input  logic                         bus_clk,
  input  logic                         bus_rst,
  // From the control module
  input  logic                         rd_hit_i,
  input  aurora_mgmt_pkg::reg_addr_t   rd_sel_i,
  // Status sources
  input  aurora_mgmt_pkg::phy_flags_t  flags_i,
  input  aurora_mgmt_pkg::lock_time_t  lock_time_i,
  input  logic                         bist_locked_i,
  input  logic                         crit_latch_i,
  input  aurora_mgmt_pkg::reg_data_t   overruns_i,
  input  aurora_mgmt_pkg::reg_data_t   checksum_errors_i,
  input  aurora_mgmt_pkg::bist_count_t bist_samps_i,
  input  aurora_mgmt_pkg::bist_count_t bist_errors_i,
  // Read response
  output logic                         rd_resp_o,
  output aurora_mgmt_pkg::reg_data_t   rd_data_o
);

  aurora_mgmt_pkg::reg_data_t core_status;
  aurora_mgmt_pkg::reg_data_t phy_status;
  aurora_mgmt_pkg::reg_data_t rd_word;

  //--------------------------------------------------
  // Status words
  //--------------------------------------------------
  assign core_status = {
    6'h00,                                              // [31:26]
    crit_latch_i,                                       // [25]
    flags_i.mmcm_locked,                                // [24]
    flags_i.gt_pll_lock,                                // [23]
    flags_i.qpll_refclk_lost,                           // [22]
    flags_i.qpll_lock,                                  // [21]
    flags_i.qpll_reset,                                 // [20]
    lock_time_i[aurora_mgmt_pkg::LOCK_TIMER_WIDTH-1:4], // [19:4] coarse latency
    bist_locked_i,                                      // [3]
    flags_i.soft_err,                                   // [2]
    flags_i.hard_err,                                   // [1]
    flags_i.channel_up                                  // [0]
  };

  assign phy_status = {30'h0, flags_i.hard_err, flags_i.channel_up};

  // Address already checked upstream, default never hit
  always_comb begin
    case (rd_sel_i)
      aurora_mgmt_pkg::REG_MAC_CTRL_STATUS: rd_word = core_status;
      aurora_mgmt_pkg::REG_PHY_STATUS:      rd_word = phy_status;
      aurora_mgmt_pkg::REG_OVERRUNS:        rd_word = overruns_i;
      aurora_mgmt_pkg::REG_CHECKSUM_ERRORS: rd_word = checksum_errors_i;
      aurora_mgmt_pkg::REG_BIST_SAMPS:      rd_word = bist_samps_i[47:16]; // Scaled by 2^16
      aurora_mgmt_pkg::REG_BIST_ERRORS:     rd_word = bist_errors_i[31:0];
      aurora_mgmt_pkg::REG_ID:              rd_word = aurora_mgmt_pkg::ID_WORD;
      default:                              rd_word = '0;
    endcase
  end

  //--------------------------------------------------
  // Output stage
  //--------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_resp_o <= 1'b0;
    end else begin
      rd_resp_o <= rd_hit_i; // One pulse per accepted read
    end
  end

  // Data holds between reads
  always_ff @(posedge bus_clk) begin
    if (rd_hit_i) begin
      rd_data_o <= rd_word;
    end
  end

endmodule

// File: logic/aurora_reg_ctrl.sv
`timescale 1ns/1ns

module aurora_reg_ctrl (
  input  logic                         bus_clk,
  input  logic                         bus_rst,
  // Register port from the bus master
  input  aurora_mgmt_pkg::reg_wr_t     reg_wr_i,
  input  logic                         reg_rd_req_i,
  input  aurora_mgmt_pkg::reg_addr_t   reg_rd_addr_i,
  // Control word and read tracking
  output aurora_mgmt_pkg::aurora_ctrl_t ctrl_o,
  output logic                         rd_hit_o,
  output aurora_mgmt_pkg::reg_addr_t   rd_sel_o
);

  logic ctrl_wr_en;
  logic rd_known;

  //--------------------------------------------------
  // Write decode
  //--------------------------------------------------
  assign ctrl_wr_en = reg_wr_i.req &&
                      (reg_wr_i.addr == aurora_mgmt_pkg::REG_MAC_CTRL_STATUS);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ctrl_o <= aurora_mgmt_pkg::aurora_ctrl_t'(aurora_mgmt_pkg::CTRL_RESET_VALUE);
    end else if (ctrl_wr_en) begin
      ctrl_o <= aurora_mgmt_pkg::aurora_ctrl_t'(reg_wr_i.data); // Whole word, reserved too
    end
  end

  //--------------------------------------------------
  // Read address check
  //--------------------------------------------------
  always_comb begin
    case (reg_rd_addr_i)
      aurora_mgmt_pkg::REG_MAC_CTRL_STATUS,
      aurora_mgmt_pkg::REG_PHY_STATUS,
      aurora_mgmt_pkg::REG_OVERRUNS,
      aurora_mgmt_pkg::REG_CHECKSUM_ERRORS,
      aurora_mgmt_pkg::REG_BIST_SAMPS,
      aurora_mgmt_pkg::REG_BIST_ERRORS,
      aurora_mgmt_pkg::REG_ID: rd_known = 1'b1;
      default:                 rd_known = 1'b0; // Unknown address, no response
    endcase
  end

  // Hit flag is control state
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_hit_o <= 1'b0;
    end else begin
      rd_hit_o <= reg_rd_req_i && rd_known;
    end
  end

  // Address only matters while rd_hit_o is high
  always_ff @(posedge bus_clk) begin
    if (reg_rd_req_i) begin
      rd_sel_o <= reg_rd_addr_i;
    end
  end

endmodule

// File: logic/bist_lock_timer.sv
`timescale 1ns/1ns

module bist_lock_timer (
  input  logic                        bus_clk,
  input  logic                        checker_en_i,
  input  logic                        locked_i,
  output aurora_mgmt_pkg::lock_time_t lock_time_o
);

  //--------------------------------------------------
  // Lock latency count
  //--------------------------------------------------
  // Counts bus cycles from checker enable until the
  // checker reports lock, then freezes so software can
  // read how long acquisition took.
  aurora_mgmt_pkg::lock_time_t count_q;

  always_ff @(posedge bus_clk) begin
    if (!locked_i) begin
      if (checker_en_i) begin
        count_q <= count_q + 1'b1; // Wraps at full width
      end else begin
        count_q <= '0;             // Idle checker, start over
      end
    end
    // Locked, hold the measured value
  end

  assign lock_time_o = count_q;

endmodule

// File: logic/status_sync.sv
`timescale 1ns/1ns

module status_sync (
  input  logic                       bus_clk,
  input  aurora_mgmt_pkg::phy_flags_t flags_i,  // Async, from the PHY side
  output aurora_mgmt_pkg::phy_flags_t flags_o   // Safe to use on bus_clk
);

  //--------------------------------------------------
  // Flop chain across the whole flag struct
  //--------------------------------------------------
  // Each flag is a slow level, so per-bit sync is enough.
  // A flag may land one cycle apart from its neighbours
  // when they toggle together, which the readers tolerate.
  aurora_mgmt_pkg::phy_flags_t sync_q [aurora_mgmt_pkg::SYNC_STAGES];

  always_ff @(posedge bus_clk) begin
    sync_q[0] <= flags_i; // First stage may go metastable
    for (int i = 1; i < aurora_mgmt_pkg::SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  // Last stage feeds the bus domain
  assign flags_o = sync_q[aurora_mgmt_pkg::SYNC_STAGES-1];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Aurora management testbench with Verilator.
# Any build error, assertion stop or nonzero exit is logged as a failure.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_aurora_mgmt_core -f compile.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_aurora_mgmt_core >> sim.log 2>&1 \
  || echo "*** TEST FAILED ***" >> sim.log

cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

// File: sim/aurora_mgmt_assertions.sv
`timescale 1ns/1ns

module aurora_mgmt_assertions (
  input logic                          bus_clk,
  input logic                          bus_rst,
  input logic                          reg_rd_req_i,
  input aurora_mgmt_pkg::reg_addr_t    reg_rd_addr_i,
  input logic                          reg_rd_resp_o,
  input aurora_mgmt_pkg::aurora_ctrl_t ctrl_o
);

  logic req_known; // Request to a register in the map

  assign req_known = reg_rd_req_i &&
                     (reg_rd_addr_i inside {aurora_mgmt_pkg::REG_MAC_CTRL_STATUS,
                                            aurora_mgmt_pkg::REG_PHY_STATUS,
                                            aurora_mgmt_pkg::REG_OVERRUNS,
                                            aurora_mgmt_pkg::REG_CHECKSUM_ERRORS,
                                            aurora_mgmt_pkg::REG_BIST_SAMPS,
                                            aurora_mgmt_pkg::REG_BIST_ERRORS,
                                            aurora_mgmt_pkg::REG_ID});

  //--------------------------------------------------
  // Register port protocol
  //--------------------------------------------------
  // A second response in a row needs its own accepted request
  property p_resp_single_pulse;
    @(posedge bus_clk) disable iff (bus_rst)
      (reg_rd_resp_o && $past(reg_rd_resp_o)) |-> $past(req_known, 2);
  endproperty

  property p_resp_has_request;
    @(posedge bus_clk) disable iff (bus_rst)
      reg_rd_resp_o |-> $past(reg_rd_req_i, 2);  // Fixed two-cycle latency
  endproperty

  property p_ctrl_known;
    @(posedge bus_clk) disable iff (bus_rst)
      !$isunknown(ctrl_o);
  endproperty

  a_resp_single_pulse: assert property (p_resp_single_pulse)
    else $error("Read response held longer than one cycle per request");

  a_resp_has_request: assert property (p_resp_has_request)
    else $error("Read response without a request two cycles earlier");

  a_ctrl_known: assert property (p_ctrl_known)
    else $error("Control word has unknown bits after reset");

endmodule

bind aurora_mgmt_core aurora_mgmt_assertions i_aurora_mgmt_assertions (
  .bus_clk      (bus_clk),
  .bus_rst      (bus_rst),
  .reg_rd_req_i (reg_rd_req_i),
  .reg_rd_addr_i(reg_rd_addr_i),
  .reg_rd_resp_o(reg_rd_resp_o),
  .ctrl_o       (ctrl_o)
);

// File: sim/tb_aurora_mgmt_core.sv
`timescale 1ns/1ns

module tb_aurora_mgmt_core;

  localparam int RESET_CYCLES   = 8;
  localparam int RUN_CYCLES     = 2000;            // Random phase length
  localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;  // Directed and drain phases are tiny

  logic                          bus_clk = 1'b0;
  logic                          bus_rst;
  aurora_mgmt_pkg::reg_wr_t      reg_wr;
  logic                          rd_req;
  aurora_mgmt_pkg::reg_addr_t    rd_addr;
  logic                          rd_resp;
  aurora_mgmt_pkg::reg_data_t    rd_data;
  aurora_mgmt_pkg::phy_flags_t   phy_flags;
  logic                          overrun_pulse;
  logic                          checksum_pulse;
  logic                          bist_locked;
  aurora_mgmt_pkg::bist_count_t  bist_samps;
  aurora_mgmt_pkg::bist_count_t  bist_errors;
  aurora_mgmt_pkg::aurora_ctrl_t ctrl;

  //--------------------------------------------------
  // Reference model state
  //--------------------------------------------------
  aurora_mgmt_pkg::aurora_ctrl_t m_ctrl;
  aurora_mgmt_pkg::lock_time_t   m_lock;
  aurora_mgmt_pkg::reg_data_t    m_ovr;
  aurora_mgmt_pkg::reg_data_t    m_cks;
  logic                          m_latch;
  aurora_mgmt_pkg::phy_flags_t   m_s1;    // Flags one edge after the PHY
  aurora_mgmt_pkg::phy_flags_t   m_s2;    // Settled flags seen by the core
  logic                          m_hit;
  aurora_mgmt_pkg::reg_addr_t    m_sel;

  int                            cycle = 0;
  int                            quiet = 0; // No reads while flags settle
  int                            due_q[$];  // Cycle each response is expected
  aurora_mgmt_pkg::reg_data_t    data_q[$];

  always #4 bus_clk = ~bus_clk;

  // Cycle count with hang guard
  always @(posedge bus_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation timed out");
    end
  end

  aurora_mgmt_core i_aurora_mgmt_core (
    .bus_clk             (bus_clk),
    .bus_rst             (bus_rst),
    .reg_wr_i            (reg_wr),
    .reg_rd_req_i        (rd_req),
    .reg_rd_addr_i       (rd_addr),
    .reg_rd_resp_o       (rd_resp),
    .reg_rd_data_o       (rd_data),
    .phy_flags_i         (phy_flags),
    .overrun_pulse_i     (overrun_pulse),
    .checksum_err_pulse_i(checksum_pulse),
    .bist_locked_i       (bist_locked),
    .bist_samps_i        (bist_samps),
    .bist_errors_i       (bist_errors),
    .ctrl_o              (ctrl)
  );

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Value check failed");
    end
  endtask

  function automatic logic known_addr(aurora_mgmt_pkg::reg_addr_t a);
    return a inside {aurora_mgmt_pkg::REG_MAC_CTRL_STATUS, aurora_mgmt_pkg::REG_PHY_STATUS,
                     aurora_mgmt_pkg::REG_OVERRUNS, aurora_mgmt_pkg::REG_CHECKSUM_ERRORS,
                     aurora_mgmt_pkg::REG_BIST_SAMPS, aurora_mgmt_pkg::REG_BIST_ERRORS,
                     aurora_mgmt_pkg::REG_ID};
  endfunction

  function automatic aurora_mgmt_pkg::reg_addr_t pick_known_addr(int n);
    case (n)
      0:       return aurora_mgmt_pkg::REG_MAC_CTRL_STATUS;
      1:       return aurora_mgmt_pkg::REG_PHY_STATUS;
      2:       return aurora_mgmt_pkg::REG_OVERRUNS;
      3:       return aurora_mgmt_pkg::REG_CHECKSUM_ERRORS;
      4:       return aurora_mgmt_pkg::REG_BIST_SAMPS;
      5:       return aurora_mgmt_pkg::REG_BIST_ERRORS;
      default: return aurora_mgmt_pkg::REG_ID;
    endcase
  endfunction

  // Word the core should capture at the next edge
  function automatic aurora_mgmt_pkg::reg_data_t expected_word(aurora_mgmt_pkg::reg_addr_t sel);
    aurora_mgmt_pkg::reg_data_t w;
    w = '0;
    case (sel)
      aurora_mgmt_pkg::REG_MAC_CTRL_STATUS: begin
        w[0]    = m_s2.channel_up;
        w[1]    = m_s2.hard_err;
        w[2]    = m_s2.soft_err;
        w[3]    = bist_locked;
        w[19:4] = m_lock[19:4];  // Coarse lock latency
        w[20]   = m_s2.qpll_reset;
        w[21]   = m_s2.qpll_lock;
        w[22]   = m_s2.qpll_refclk_lost;
        w[23]   = m_s2.gt_pll_lock;
        w[24]   = m_s2.mmcm_locked;
        w[25]   = m_latch;
      end
      aurora_mgmt_pkg::REG_PHY_STATUS: begin
        w[0] = m_s2.channel_up;
        w[1] = m_s2.hard_err;
      end
      aurora_mgmt_pkg::REG_OVERRUNS:        w = m_ovr;
      aurora_mgmt_pkg::REG_CHECKSUM_ERRORS: w = m_cks;
      aurora_mgmt_pkg::REG_BIST_SAMPS:      w = bist_samps[47:16];
      aurora_mgmt_pkg::REG_BIST_ERRORS:     w = bist_errors[31:0];
      aurora_mgmt_pkg::REG_ID:              w = aurora_mgmt_pkg::ID_WORD;
      default:                              w = '0;
    endcase
    return w;
  endfunction

  // Advance the model over the edge that just passed
  task automatic model_step();
    logic clear;
    clear = bus_rst || m_ctrl.mac_clear;
    if (!bist_locked) begin
      if (m_ctrl.checker_en) begin
        m_lock = m_lock + 20'd1;
      end else begin
        m_lock = '0;
      end
    end
    if (clear) begin
      m_ovr   = '0;
      m_cks   = '0;
      m_latch = 1'b0;
    end else begin
      if (overrun_pulse) m_ovr = m_ovr + 32'd1;
      if (checksum_pulse) m_cks = m_cks + 32'd1;
      if (m_s2.crit_err) m_latch = 1'b1;
    end
    m_hit = !bus_rst && rd_req && known_addr(rd_addr);
    m_sel = rd_addr;
    m_s2  = m_s1;
    m_s1  = phy_flags;
    if (bus_rst) begin
      m_ctrl = aurora_mgmt_pkg::aurora_ctrl_t'(aurora_mgmt_pkg::CTRL_RESET_VALUE);
    end else if (reg_wr.req && reg_wr.addr == aurora_mgmt_pkg::REG_MAC_CTRL_STATUS) begin
      m_ctrl = reg_wr.data;
    end
  endtask

  // Falling edge: update model, then compare outputs
  task automatic sample_cycle();
    logic exp_resp;
    @(negedge bus_clk);
    model_step();
    check_value("ctrl_o", ctrl, m_ctrl);
    exp_resp = (due_q.size() != 0) && (due_q[0] == cycle);
    check_value("reg_rd_resp_o", 32'(rd_resp), 32'(exp_resp));
    if (exp_resp) begin
      check_value("reg_rd_data_o", rd_data, data_q[0]);
      void'(due_q.pop_front());
      void'(data_q.pop_front());
    end
  endtask

  // After new inputs are driven, so BIST words match the capture edge
  task automatic queue_read();
    if (m_hit) begin
      due_q.push_back(cycle + 1);
      data_q.push_back(expected_word(m_sel));
    end
  endtask

  task automatic drive_idle();
    reg_wr         = '0;
    rd_req         = 1'b0;
    rd_addr        = '0;
    overrun_pulse  = 1'b0;
    checksum_pulse = 1'b0;
  endtask

  task automatic drive_random();
    reg_wr.req     = ($urandom % 4) == 0;
    reg_wr.addr    = (($urandom % 4) == 0) ? aurora_mgmt_pkg::REG_MAC_CTRL_STATUS
                                           : 14'($urandom);
    reg_wr.data    = $urandom;
    reg_wr.data[10] = ($urandom % 6) == 0;  // mac_clear only now and then
    overrun_pulse  = ($urandom % 3) == 0;
    checksum_pulse = ($urandom % 3) == 0;
    if (($urandom % 16) == 0) bist_locked = !bist_locked;
    bist_samps  = 48'({$urandom, $urandom});
    bist_errors = 48'({$urandom, $urandom});
    if (quiet > 0) begin
      quiet--;
    end else if (($urandom % 24) == 0) begin
      phy_flags          = 9'($urandom);
      phy_flags.crit_err = ($urandom % 4) == 0;
      quiet              = 4;
    end
    rd_req  = (quiet == 0) && (($urandom % 2) == 0);
    rd_addr = (($urandom % 4) != 0) ? pick_known_addr(int'($urandom % 7)) : 14'($urandom);
  endtask

  initial begin
    void'($urandom(32'h97882a72));
    bus_rst        = 1'b1;
    bist_locked    = 1'b0;  // Low until the lock timer has been cleared
    bist_samps     = '0;
    bist_errors    = '0;
    phy_flags      = 9'($urandom);
    phy_flags.crit_err = 1'b0;
    drive_idle();
    m_ctrl  = aurora_mgmt_pkg::aurora_ctrl_t'(aurora_mgmt_pkg::CTRL_RESET_VALUE);
    m_lock  = '0;
    m_ovr   = '0;
    m_cks   = '0;
    m_latch = 1'b0;
    m_s1    = phy_flags;
    m_s2    = phy_flags;
    m_hit   = 1'b0;
    m_sel   = '0;

    repeat (RESET_CYCLES) begin
      sample_cycle();
      drive_idle();
      queue_read();
    end
    bus_rst = 1'b0;
    check_value("ctrl_o", ctrl, aurora_mgmt_pkg::CTRL_RESET_VALUE);

    // Disable the checker once so the lock timer starts from zero
    sample_cycle();
    drive_idle();
    reg_wr.req  = 1'b1;
    reg_wr.addr = aurora_mgmt_pkg::REG_MAC_CTRL_STATUS;
    reg_wr.data = '0;
    queue_read();

    // ID read, unknown address, then two back-to-back ID reads
    sample_cycle();
    drive_idle();
    rd_req  = 1'b1;
    rd_addr = aurora_mgmt_pkg::REG_ID;
    queue_read();
    sample_cycle();
    drive_idle();
    rd_req  = 1'b1;
    rd_addr = 14'h0123;
    queue_read();
    repeat (2) begin
      sample_cycle();
      drive_idle();
      rd_req  = 1'b1;
      rd_addr = aurora_mgmt_pkg::REG_ID;
      queue_read();
    end

    //--------------------------------------------------
    // Random traffic
    //--------------------------------------------------
    repeat (RUN_CYCLES) begin
      sample_cycle();
      drive_random();
      queue_read();
    end

    // Read pipeline is two deep
    repeat (4) begin
      sample_cycle();
      drive_idle();
      queue_read();
    end
    check_value("pending responses", 32'(due_q.size()), 32'd0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
